// File: project.f
logic/rvDecodePkg.sv
logic/immDecoder.sv
logic/controlDecoder.sv
logic/decodeSkidBuffer.sv
logic/decodeUnit.sv
bench/decodeUnit_props.sv
bench/decodeUnitTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= decodeUnitTb
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/decodeUnitTb.sv
`timescale 1ns/1ps

module decodeUnitTb;

    import rvDecodePkg::*;

    localparam int Timeout = 200;

    typedef struct packed {
        logic [31:0] word;
        logic [7:0]  tag;
        logic [31:0] imm;
        instrClassT  instrClass;
        aluOpT       aluOp;
        logic        writesRd;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
    } vectorT;

    logic         clk = 1'b0;
    logic         rst;
    logic [31:0]  instr;
    logic [7:0]   tag;
    logic         inValid;
    logic         inReady;
    decodedInstrT out;
    logic         outValid;
    logic         outReady;

    vectorT vectors[$];
    string  names[$];
    integer seed = 78;
    int     errorCount = 0;
    int     passCount = 0;
    int     failCount = 0;
    int     received = 0;

    always #2 clk = ~clk;

    decodeUnit dut_i (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .tag      (tag),
        .inValid  (inValid),
        .inReady  (inReady),
        .out      (out),
        .outValid (outValid),
        .outReady (outReady)
    );

    // Counts every output transfer, independent of the receive loop
    always @(posedge clk) begin
        if (outValid && outReady) begin
            received++;
        end
    end

    task automatic addVector(input string name, input logic [31:0] word, input logic [7:0] vecTag,
                             input logic [31:0] imm, input instrClassT cls, input aluOpT op,
                             input logic wr, input logic [4:0] rdIdx, input logic [4:0] rs1Idx,
                             input logic [4:0] rs2Idx, input logic [2:0] f3);
        names.push_back(name);
        vectors.push_back(vectorT'{word, vecTag, imm, cls, op, wr, rdIdx, rs1Idx, rs2Idx, f3});
    endtask

    task automatic buildTable();
        addVector("addiNeg",    32'hFFB00093, 8'h10, 32'hFFFFFFFB, clsAluImm,  aluAdd,   1'b1,
                  5'd1,  5'd0,  5'd27, 3'd0);
        addVector("addiPos",    32'h06418113, 8'h11, 32'h00000064, clsAluImm,  aluAdd,   1'b1,
                  5'd2,  5'd3,  5'd4,  3'd0);
        addVector("srai",       32'h40735293, 8'h12, 32'h00000007, clsAluImm,  aluSra,   1'b1,
                  5'd5,  5'd6,  5'd7,  3'd5);
        addVector("sw",         32'hFE742C23, 8'h13, 32'hFFFFFFF8, clsStore,   aluAdd,   1'b0,
                  5'd24, 5'd8,  5'd7,  3'd2);
        addVector("beq",        32'hFE2088E3, 8'h14, 32'hFFFFFFF0, clsBranch,  aluSub,   1'b0,
                  5'd17, 5'd1,  5'd2,  3'd0);
        addVector("lui",        32'h12345537, 8'h15, 32'h12345000, clsLui,     aluPassB, 1'b1,
                  5'd10, 5'd8,  5'd3,  3'd5);
        addVector("auipc",      32'hFFFFF597, 8'h16, 32'hFFFFF000, clsAuipc,   aluAdd,   1'b1,
                  5'd11, 5'd31, 5'd31, 3'd7);
        addVector("jal",        32'hFFDFF0EF, 8'h17, 32'hFFFFFFFC, clsJal,     aluAdd,   1'b1,
                  5'd1,  5'd31, 5'd29, 3'd7);
        addVector("jalrRdZero", 32'hFF408067, 8'h18, 32'hFFFFFFF4, clsJalr,    aluAdd,   1'b0,
                  5'd0,  5'd1,  5'd20, 3'd0);
        addVector("csrrwi",     32'h3008D1F3, 8'h19, 32'h00000011, clsCsr,     aluAdd,   1'b1,
                  5'd3,  5'd17, 5'd0,  3'd5);
        addVector("csrrsi",     32'h305FE273, 8'h1A, 32'h0000001F, clsCsr,     aluAdd,   1'b1,
                  5'd4,  5'd31, 5'd5,  3'd6);
        addVector("csrrciRd0",  32'h3402F073, 8'h1B, 32'h00000005, clsCsr,     aluAdd,   1'b0,
                  5'd0,  5'd5,  5'd0,  3'd7);
        addVector("add",        32'h00B504B3, 8'h1C, 32'h0000000A, clsAlu,     aluAdd,   1'b1,
                  5'd9,  5'd10, 5'd11, 3'd0);
        addVector("sub",        32'h40B504B3, 8'h1D, 32'h0000000A, clsAlu,     aluSub,   1'b1,
                  5'd9,  5'd10, 5'd11, 3'd0);
        addVector("srl",        32'h00E6D633, 8'h1E, 32'h0000000D, clsAlu,     aluSrl,   1'b1,
                  5'd12, 5'd13, 5'd14, 3'd5);
        addVector("sra",        32'h40E6D633, 8'h1F, 32'h0000000D, clsAlu,     aluSra,   1'b1,
                  5'd12, 5'd13, 5'd14, 3'd5);
        addVector("lowBits00",  32'h00000000, 8'h20, 32'h00000000, clsIllegal, aluAdd,   1'b0,
                  5'd0,  5'd0,  5'd0,  3'd0);
        addVector("badOpcode",  32'h0000007F, 8'h21, 32'h00000000, clsIllegal, aluAdd,   1'b0,
                  5'd0,  5'd0,  5'd0,  3'd0);
    endtask

    task automatic reportMismatch(input int idx, input string field,
                                  input logic [31:0] expected, input logic [31:0] actual);
        $display("[FAIL] %s %s expected %h actual %h", names[idx], field, expected, actual);
        errorCount++;
    endtask

    task automatic checkRecord(input int idx, input decodedInstrT got);
        vectorT want;
        int     errorsBefore;
        want = vectors[idx];
        errorsBefore = errorCount;
        assert (got.tag == want.tag) else reportMismatch(idx, "tag", 32'(want.tag), 32'(got.tag));
        assert (got.imm == want.imm) else reportMismatch(idx, "imm", want.imm, got.imm);
        assert (got.instrClass == want.instrClass)
            else reportMismatch(idx, "class", 32'(want.instrClass), 32'(got.instrClass));
        // ALU operation is a don't-care for illegal and CSR words
        assert (want.instrClass inside {clsIllegal, clsCsr} || got.aluOp == want.aluOp)
            else reportMismatch(idx, "aluOp", 32'(want.aluOp), 32'(got.aluOp));
        assert (got.writesRd == want.writesRd)
            else reportMismatch(idx, "writesRd", 32'(want.writesRd), 32'(got.writesRd));
        assert (got.illegal == (want.instrClass == clsIllegal))
            else reportMismatch(idx, "illegal", 32'(want.instrClass == clsIllegal),
                                32'(got.illegal));
        assert (got.rd == want.rd) else reportMismatch(idx, "rd", 32'(want.rd), 32'(got.rd));
        assert (got.rs1 == want.rs1)
            else reportMismatch(idx, "rs1", 32'(want.rs1), 32'(got.rs1));
        assert (got.rs2 == want.rs2)
            else reportMismatch(idx, "rs2", 32'(want.rs2), 32'(got.rs2));
        assert (got.funct3 == want.funct3)
            else reportMismatch(idx, "funct3", 32'(want.funct3), 32'(got.funct3));
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("%s: ok", names[idx]);
        end else begin
            failCount++;
            $display("%s: %0d mismatches", names[idx], errorCount - errorsBefore);
        end
    endtask

    task automatic sendAll();
        int waitCycles;
        for (int i = 0; i < vectors.size(); i++) begin
            instr   <= vectors[i].word;
            tag     <= vectors[i].tag;
            inValid <= 1'b1;
            waitCycles = 0;
            @(negedge clk);
            while (!inReady && waitCycles < Timeout) begin
                @(negedge clk);
                waitCycles++;
            end
            if (!inReady) begin
                $display("Timed out waiting for inReady while sending %s", names[i]);
                errorCount++;
                return;
            end
            @(posedge clk); // Transfer edge
        end
        inValid <= 1'b0;
    endtask

    task automatic receiveAll();
        int           waitCycles;
        int unsigned  randVal;
        decodedInstrT got;
        for (int i = 0; i < vectors.size(); i++) begin
            waitCycles = 0;
            do begin
                @(posedge clk);
                randVal = $random(seed);
                outReady <= (randVal % 100) < 60; // Roughly 60 percent ready
                @(negedge clk);
                waitCycles++;
            end while (!(outValid && outReady) && waitCycles < Timeout);
            if (!(outValid && outReady)) begin
                $display("Timed out waiting for output record %0d of %0d", i + 1, vectors.size());
                errorCount++;
                return;
            end
            got = out;
            checkRecord(i, got);
        end
        @(posedge clk);
        outReady <= 1'b0;
        @(negedge clk);
        assert (!outValid) else begin
            $display("An extra output record appeared after the last test");
            errorCount++;
        end
    endtask

    initial begin
        rst      = 1'b1;
        instr    = '0;
        tag      = '0;
        inValid  = 1'b0;
        outReady = 1'b0;
        buildTable();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        fork
            sendAll();
            receiveAll();
        join
        assert (received == vectors.size()) else begin
            $display("Received %0d records but the table holds %0d", received, vectors.size());
            errorCount++;
        end
        $display("Summary: %0d tests, %0d ok, %0d with mismatches, %0d errors",
                 vectors.size(), passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: bench/decodeUnit_props.sv
`timescale 1ns/1ps

module decodeUnitProps (
    input logic                      clk,
    input logic                      rst,
    input logic                      inValid,
    input logic                      inReady,
    input rvDecodePkg::decodedInstrT out,
    input logic                      outValid,
    input logic                      outReady
);

    resetEmpty: assert property (@(posedge clk) rst |=> !outValid) // Comes up empty
        else $error("outValid high in the cycle after reset");

    outputHeld: assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(out)))
        else $error("Output record changed while stalled");

    // A lone output transfer leaves at most one entry
    drainFreesSlot: assert property (@(posedge clk) disable iff (rst)
        (outValid && outReady && !(inValid && inReady)) |=> inReady)
        else $error("inReady low after an entry was freed");

endmodule

bind decodeUnit decodeUnitProps props_i (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .out      (out),
    .outValid (outValid),
    .outReady (outReady)
);

// File: logic/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [31:0]               instr,
    input  logic [7:0]                tag,
    input  logic                      inValid,
    output logic                      inReady,
    output rvDecodePkg::decodedInstrT out,
    output logic                      outValid,
    input  logic                      outReady
);

    import rvDecodePkg::*;

    logic [31:0]  imm;
    instrClassT   instrClass;
    aluOpT        aluOp;
    logic         writesRd;
    logic         illegal;
    decodedInstrT decoded;

    immDecoder immDecoder_i (
        .instr (instr),
        .imm   (imm)
    );

    controlDecoder controlDecoder_i (
        .instr      (instr),
        .instrClass (instrClass),
        .aluOp      (aluOp),
        .writesRd   (writesRd),
        .illegal    (illegal)
    );

    // Register fields come straight from the word
    assign decoded = '{
        instrClass: instrClass,
        aluOp:      aluOp,
        rd:         instr[11:7],
        rs1:        instr[19:15],
        rs2:        instr[24:20],
        funct3:     instr[14:12],
        writesRd:   writesRd,
        illegal:    illegal,
        imm:        imm,
        tag:        tag
    };

    decodeSkidBuffer decodeSkidBuffer_i (
        .clk      (clk),
        .rst      (rst),
        .inData   (decoded),
        .inValid  (inValid),
        .inReady  (inReady),
        .outData  (out),
        .outValid (outValid),
        .outReady (outReady)
    );

endmodule

// File: logic/decodeSkidBuffer.sv
`timescale 1ns/1ps

module decodeSkidBuffer (
    input  logic                      clk,
    input  logic                      rst,
    input  rvDecodePkg::decodedInstrT inData,
    input  logic                      inValid,
    output logic                      inReady,
    output rvDecodePkg::decodedInstrT outData,
    output logic                      outValid,
    input  logic                      outReady
);

    import rvDecodePkg::*;

    typedef enum logic [1:0] {
        occEmpty,
        occOne,
        occTwo
    } occupancyT;

    occupancyT    state;
    occupancyT    stateNext;
    decodedInstrT mainData;   // Head item, drives the output
    decodedInstrT skidData;   // Second item, caught while the output stalls
    logic         inFire;
    logic         outFire;

    assign inReady  = (state != occTwo); // From state only, never from outReady
    assign outValid = (state != occEmpty);
    assign outData  = mainData;

    assign inFire  = inValid && inReady;
    assign outFire = outValid && outReady;

    always_comb begin
        stateNext = state;
        case (state)
            occEmpty: if (inFire) stateNext = occOne;
            occOne: begin
                if (inFire && !outFire) begin
                    stateNext = occTwo;
                end else if (!inFire && outFire) begin
                    stateNext = occEmpty;
                end
            end
            default:  if (outFire) stateNext = occOne; // Skid moves up to main
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= occEmpty;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk) begin
        if (state == occTwo) begin
            if (outFire) mainData <= skidData;
        end else if (inFire) begin
            // Stalled head keeps its slot, newcomer goes to the skid
            if (state == occOne && !outFire) begin
                skidData <= inData;
            end else begin
                mainData <= inData;
            end
        end
    end

endmodule

// File: logic/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
    input  logic [31:0]             instr,
    output rvDecodePkg::instrClassT instrClass,
    output rvDecodePkg::aluOpT      aluOp,
    output logic                    writesRd,
    output logic                    illegal
);

    import rvDecodePkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic       altBit;      // Instruction bit 30, funct7[5]
    logic       lowBitsOk;   // 32-bit encoding marker

    assign opcode    = opcodeT'(instr[6:2]);
    assign funct3    = instr[14:12];
    assign rd        = instr[11:7];
    assign altBit    = instr[30];
    assign lowBitsOk = (instr[1:0] == 2'b11);

    // Shared by OP and OP-IMM, alt selects SUB or SRA
    function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic alt);
        aluOpT result;
        case (f3)
            3'b000:  result = alt ? aluSub : aluAdd;
            3'b001:  result = aluSll;
            3'b010:  result = aluSlt;
            3'b011:  result = aluSltu;
            3'b100:  result = aluXor;
            3'b101:  result = alt ? aluSra : aluSrl;
            3'b110:  result = aluOr;
            default: result = aluAnd;
        endcase
        return result;
    endfunction

    always_comb begin
        instrClass = clsIllegal;
        aluOp      = aluAdd;       // Address add for loads, stores, jumps, auipc
        if (lowBitsOk) begin
            case (opcode)
                load:    instrClass = clsLoad;
                store:   instrClass = clsStore;
                op: begin
                    instrClass = clsAlu;
                    aluOp      = aluFromFunct3(funct3, altBit);
                end
                opImm: begin
                    instrClass = clsAluImm;
                    // No SUBI, so bit 30 matters only for SRAI
                    aluOp      = aluFromFunct3(funct3, (funct3 == 3'b101) && altBit);
                end
                branch: begin
                    instrClass = clsBranch;
                    aluOp      = aluSub; // Compare by subtraction
                end
                jal:     instrClass = clsJal;
                jalr:    instrClass = clsJalr;
                lui: begin
                    instrClass = clsLui;
                    aluOp      = aluPassB;
                end
                auipc:   instrClass = clsAuipc;
                system:  instrClass = clsCsr;
                miscMem: instrClass = clsFence;
                default: instrClass = clsIllegal;
            endcase
        end
    end

    assign illegal = (instrClass == clsIllegal);

    always_comb begin
        case (instrClass)
            clsStore, clsBranch, clsFence, clsIllegal: writesRd = 1'b0;
            default:                                   writesRd = (rd != 5'd0); // x0 is discarded
        endcase
    end

endmodule

// File: logic/immDecoder.sv
`timescale 1ns/1ps

module immDecoder (
    input  logic [31:0] instr,
    output logic [31:0] imm
);

    import rvDecodePkg::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic [4:0] rs1;

    assign opcode = opcodeT'(instr[6:2]); // Bits 1..0 are checked by the control decoder
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];

    always_comb begin
        case (opcode)
            load, opImm: begin
                if (opcode == opImm && funct3[1:0] == 2'b01) begin // SLLI, SRLI, SRAI
                    imm[31:5] = '0;
                    imm[4:0]  = instr[24:20];
                end else begin
                    imm[31:12] = {20{instr[31]}};
                    imm[11:0]  = instr[31:20];
                end
            end

            jalr: begin
                imm[31:12] = {20{instr[31]}};
                imm[11:0]  = instr[31:20];
            end

            store: begin
                imm[31:12] = {20{instr[31]}};
                imm[11:5]  = instr[31:25];
                imm[4:0]   = instr[11:7];
            end

            branch: begin
                imm[31:13] = {19{instr[31]}};
                imm[12]    = instr[31];
                imm[11]    = instr[7];
                imm[10:5]  = instr[30:25];
                imm[4:1]   = instr[11:8];
                imm[0]     = 1'b0; // Halfword aligned
            end

            lui, auipc: begin
                imm[31:12] = instr[31:12];
                imm[11:0]  = '0;
            end

            jal: begin
                imm[31:21] = {11{instr[31]}};
                imm[20]    = instr[31];
                imm[19:12] = instr[19:12];
                imm[11]    = instr[20];
                imm[10:1]  = instr[30:21];
                imm[0]     = 1'b0;
            end

            // CSRRWI, CSRRSI, CSRRCI take the uimm from the rs1 slot
            default: begin
                imm = {27'b0, rs1};
            end
        endcase
    end

endmodule

// File: logic/rvDecodePkg.sv
package rvDecodePkg;

    // Major opcode, instruction bits 6..2
    typedef enum logic [4:0] {
        load    = 5'b00000,
        miscMem = 5'b00011, // FENCE
        opImm   = 5'b00100,
        auipc   = 5'b00101,
        store   = 5'b01000,
        op      = 5'b01100,
        lui     = 5'b01101,
        branch  = 5'b11000,
        jalr    = 5'b11001,
        jal     = 5'b11011,
        system  = 5'b11100  // Zicsr lives here
    } opcodeT;

    typedef enum logic [3:0] {
        clsLoad,
        clsStore,
        clsAlu,
        clsAluImm,
        clsBranch,
        clsJal,
        clsJalr,
        clsLui,
        clsAuipc,
        clsCsr,
        clsFence,
        clsIllegal
    } instrClassT;

    // Follows funct3 order for OP with SUB and SRA after their partners
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB    // Result is operand B, used by LUI
    } aluOpT;

    typedef struct packed {
        instrClassT  instrClass;
        aluOpT       aluOp;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic        writesRd;
        logic        illegal;
        logic [31:0] imm;
        logic [7:0]  tag;        // Fetch tag, passed through untouched
    } decodedInstrT;

endpackage
